// ==== rtl/pkt_sync_pkg.sv ====
/*
 shared types for the header/payload rejoin stage.
 beat structs are packed with data in the upper bits and the
 sideband fields below it, so the field order here is the wire order.
 the register map is four 16-bit words on a 2-bit address.
*/

package pkt_sync_pkg;

   // ------------------------------
   // packet id and beat formats
   // ------------------------------

   // packet id carried by every beat of both streams.
   typedef logic [7:0] pid_t;

   // header beat, 45 bits.
   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  keep;
      logic        last;
      pid_t        pid;
   } hdr_beat_t;

   // payload beat, 82 bits.
   // hdr_tlast marks the beat that pairs with the last header beat.
   typedef struct packed {
      logic [63:0] data;
      logic [7:0]  keep;
      logic        last;
      pid_t        pid;
      logic        hdr_tlast;
   } pay_beat_t;

   // ------------------------------
   // synchronizer mode
   // ------------------------------

   // sop meets the first beats, hdr_tlast meets the header boundary.
   typedef enum logic [0:0] {
      SOP       = 1'b0,
      HDR_TLAST = 1'b1
   } sync_mode_t;

   // ------------------------------
   // register map
   // ------------------------------

   typedef logic [1:0]  reg_addr_t;
   typedef logic [15:0] reg_data_t;

   // bit 0 selects the mode.
   localparam reg_addr_t REG_MODE     = 2'd0;
   // released-pair count, a write clears it.
   localparam reg_addr_t REG_PAIRS    = 2'd1;
   // pid-mismatch episode count, a write clears it.
   localparam reg_addr_t REG_MISMATCH = 2'd2;
   // bit 0 is the live sop_mismatch flag.
   localparam reg_addr_t REG_STATUS   = 2'd3;

endpackage

// ==== rtl/stream_fifo.sv ====
/*
 valid/ready buffer FIFO for one beat stream.
 DEPTH must be a power of two and at least 2.
 in_ready drops when full, even if a read happens in that cycle.
 a beat written in one cycle shows on the output one cycle later.
 the output beat holds steady until it is read.
*/

`timescale 1ns/10ps

module stream_fifo #(
   parameter type BEAT_T = logic,
   parameter int  DEPTH  = 4
) (
   input  logic  axi4s_in0,
   input  logic  arst_n,

   input  logic  in_valid,
   output logic  in_ready,
   input  BEAT_T in_beat,

   output logic  out_valid,
   input  logic  out_ready,
   output BEAT_T out_beat
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   // storage, no reset on payload.
   BEAT_T mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;
   logic             rd_en;

   // ------------------------------
   // handshake
   // ------------------------------

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign wr_en     = in_valid && in_ready;
   assign rd_en     = out_valid && out_ready;

   // head of the queue, addressed by the registered read pointer.
   assign out_beat = mem[rd_ptr];

   // ------------------------------
   // storage and pointers
   // ------------------------------

   always_ff @(posedge axi4s_in0) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_beat;
      end
   end

   // pointers wrap on their own since DEPTH is a power of two.
   always_ff @(posedge axi4s_in0 or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // occupancy moves only when one side transfers alone.
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ------------------------------
   // checks
   // ------------------------------

   // occupancy stays within DEPTH, and a full FIFO has its write pointer back on the head.
   a_no_write_full: assert property (
      @(posedge axi4s_in0) disable iff (!arst_n)
      (count <= CNT_W'(DEPTH)) && ((count != CNT_W'(DEPTH)) || (wr_ptr == rd_ptr))
   );

   // an empty FIFO has its read pointer caught up with the write pointer.
   a_no_read_empty: assert property (
      @(posedge axi4s_in0) disable iff (!arst_n)
      (count == '0) |-> (wr_ptr == rd_ptr)
   );

endmodule

// ==== rtl/stream_sync.sv ====
/*
 holds back whichever stream reaches its sync point first.
 in0 must carry headers and in1 payloads, the hdr_tlast mode reads
 in1_beat.hdr_tlast. purely combinational from in to out.
 mode should only change while both streams are idle.
 after a pid mismatch the streams stay stalled until reset.
*/

`timescale 1ns/10ps

module stream_sync #(
   parameter type HDR_T = pkt_sync_pkg::hdr_beat_t,
   parameter type PAY_T = pkt_sync_pkg::pay_beat_t
) (
   input  logic                     axi4s_in0,
   input  logic                     arst_n,
   input  pkt_sync_pkg::sync_mode_t mode,

   input  logic                     in0_valid,
   output logic                     in0_ready,
   input  HDR_T                     in0_beat,
   input  logic                     in1_valid,
   output logic                     in1_ready,
   input  PAY_T                     in1_beat,

   output logic                     out0_valid,
   input  logic                     out0_ready,
   output HDR_T                     out0_beat,
   output logic                     out1_valid,
   input  logic                     out1_ready,
   output PAY_T                     out1_beat,

   output logic                     sync_event,
   output logic                     sop_mismatch
);

   logic sop0, sop1;
   logic xfer0, xfer1;
   logic both_sop, pid_match;
   logic at0, at1;
   logic sync_raw, sync_cond;
   logic rel0, rel1;
   logic stretch0, stretch1;

   // ------------------------------
   // start of packet tracking
   // ------------------------------

   assign xfer0 = in0_valid && in0_ready;
   assign xfer1 = in1_valid && in1_ready;

   // next beat is a sop after reset and after a last beat.
   always_ff @(posedge axi4s_in0 or negedge arst_n) begin
      if (!arst_n) begin
         sop0 <= 1'b1;
         sop1 <= 1'b1;
      end else begin
         if (xfer0) begin
            sop0 <= in0_beat.last;
         end
         if (xfer1) begin
            sop1 <= in1_beat.last;
         end
      end
   end

   // ------------------------------
   // sync condition
   // ------------------------------

   assign both_sop  = in0_valid && sop0 && in1_valid && sop1;
   assign pid_match = (in0_beat.pid == in1_beat.pid);

   // at0/at1 say the stream sits on its sync point.
   always_comb begin
      at0      = 1'b0;
      at1      = 1'b0;
      sync_raw = 1'b0;
      case (mode)
         pkt_sync_pkg::SOP: begin
            at0      = sop0;
            at1      = sop1;
            sync_raw = both_sop && pid_match;
         end
         pkt_sync_pkg::HDR_TLAST: begin
            at0      = in0_valid && in0_beat.last;
            at1      = in1_valid && in1_beat.hdr_tlast;
            sync_raw = at0 && at1;
         end
      endcase
   end

   // a new meeting waits until the previous one has fully handed over.
   assign sync_cond  = sync_raw && !stretch0 && !stretch1;
   assign sync_event = sync_cond;

   // release when not at the point, on sync, or while stretched.
   assign rel0 = sync_cond || stretch0 || !at0;
   assign rel1 = sync_cond || stretch1 || !at1;

   // only meaningful in sop mode, the stretched side is still the old pair.
   assign sop_mismatch = (mode == pkt_sync_pkg::SOP) && both_sop && !pid_match &&
                         !stretch0 && !stretch1;

   // ------------------------------
   // stretch registers
   // ------------------------------

   // keep a side released after sync until its own output takes the beat.
   always_ff @(posedge axi4s_in0 or negedge arst_n) begin
      if (!arst_n) begin
         stretch0 <= 1'b0;
         stretch1 <= 1'b0;
      end else begin
         if (out0_ready) begin
            stretch0 <= 1'b0;
         end else if (sync_cond) begin
            stretch0 <= 1'b1;
         end
         if (out1_ready) begin
            stretch1 <= 1'b0;
         end else if (sync_cond) begin
            stretch1 <= 1'b1;
         end
      end
   end

   // ------------------------------
   // stream signalling
   // ------------------------------

   assign in0_ready  = out0_ready && rel0;
   assign out0_valid = in0_valid && rel0;
   assign out0_beat  = in0_beat;

   assign in1_ready  = out1_ready && rel1;
   assign out1_valid = in1_valid && rel1;
   assign out1_beat  = in1_beat;

   // ------------------------------
   // checks
   // ------------------------------

   // a shown beat stays shown and unchanged until taken, relies on the FIFO hold.
   a_out0_hold: assert property (
      @(posedge axi4s_in0) disable iff (!arst_n)
      out0_valid && !out0_ready |=> out0_valid && $stable(out0_beat)
   );

   a_out1_hold: assert property (
      @(posedge axi4s_in0) disable iff (!arst_n)
      out1_valid && !out1_ready |=> out1_valid && $stable(out1_beat)
   );

   // a meeting that a side could not hand over at once is not followed by another.
   a_no_event_stretch: assert property (
      @(posedge axi4s_in0) disable iff (!arst_n)
      sync_event && !(out0_ready && out1_ready) |=> !sync_event
   );

endmodule

// ==== rtl/sync_regs.sv ====
/*
 mode register and status counters beside the synchronizer.
 writes take effect in the next cycle, reads are combinational.
 both counters saturate at 16'hffff, a write to either clears it.
 the mismatch count steps once per rising edge of sop_mismatch.
*/

`timescale 1ns/10ps

module sync_regs (
   input  logic                     axi4s_in0,
   input  logic                     arst_n,

   input  logic                     cfg_wr,
   input  pkt_sync_pkg::reg_addr_t  cfg_addr,
   input  pkt_sync_pkg::reg_data_t  cfg_wdata,
   output pkt_sync_pkg::reg_data_t  cfg_rdata,

   input  logic                     sync_event,
   input  logic                     sop_mismatch,
   output pkt_sync_pkg::sync_mode_t mode
);

   pkt_sync_pkg::reg_data_t pair_cnt;
   pkt_sync_pkg::reg_data_t mism_cnt;
   logic                    mism_q;
   logic                    mism_rise;
   logic                    wr_mode, clr_pairs, clr_mism;

   // ------------------------------
   // write decode
   // ------------------------------

   assign wr_mode   = cfg_wr && (cfg_addr == pkt_sync_pkg::REG_MODE);
   assign clr_pairs = cfg_wr && (cfg_addr == pkt_sync_pkg::REG_PAIRS);
   assign clr_mism  = cfg_wr && (cfg_addr == pkt_sync_pkg::REG_MISMATCH);

   // one count per mismatch episode.
   assign mism_rise = sop_mismatch && !mism_q;

   always_ff @(posedge axi4s_in0 or negedge arst_n) begin
      if (!arst_n) begin
         mode     <= pkt_sync_pkg::SOP;
         pair_cnt <= '0;
         mism_cnt <= '0;
         mism_q   <= 1'b0;
      end else begin
         mism_q <= sop_mismatch;
         if (wr_mode) begin
            mode <= pkt_sync_pkg::sync_mode_t'(cfg_wdata[0]);
         end
         // clear wins over a same-cycle increment.
         if (clr_pairs) begin
            pair_cnt <= '0;
         end else if (sync_event && (pair_cnt != '1)) begin
            pair_cnt <= pair_cnt + 1'b1;
         end
         if (clr_mism) begin
            mism_cnt <= '0;
         end else if (mism_rise && (mism_cnt != '1)) begin
            mism_cnt <= mism_cnt + 1'b1;
         end
      end
   end

   // ------------------------------
   // read mux
   // ------------------------------

   always_comb begin
      cfg_rdata = '0;
      case (cfg_addr)
         pkt_sync_pkg::REG_MODE:     cfg_rdata[0] = mode;
         pkt_sync_pkg::REG_PAIRS:    cfg_rdata    = pair_cnt;
         pkt_sync_pkg::REG_MISMATCH: cfg_rdata    = mism_cnt;
         pkt_sync_pkg::REG_STATUS:   cfg_rdata[0] = sop_mismatch;
      endcase
   end

   // a mismatched pair stays stalled, so it never counts as a released pair.
   a_mism_no_pair: assert property (
      @(posedge axi4s_in0) disable iff (!arst_n)
      sop_mismatch |-> !sync_event
   );

endmodule

// ==== rtl/pkt_sync_top.sv ====
/*
 header/payload rejoin stage, one FIFO per stream ahead of the synchronizer.
 hdr_out and pay_out readys are independent of each other.
 FIFO_DEPTH must be a power of two and at least 2.
 after reset mode is sop and both counts read zero.
*/

`timescale 1ns/10ps

module pkt_sync_top #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                    axi4s_in0,
   input  logic                    arst_n,

   // header and payload ingress.
   input  logic                    hdr_in_valid,
   output logic                    hdr_in_ready,
   input  pkt_sync_pkg::hdr_beat_t hdr_in_beat,
   input  logic                    pay_in_valid,
   output logic                    pay_in_ready,
   input  pkt_sync_pkg::pay_beat_t pay_in_beat,

   // synchronized egress.
   output logic                    hdr_out_valid,
   input  logic                    hdr_out_ready,
   output pkt_sync_pkg::hdr_beat_t hdr_out_beat,
   output logic                    pay_out_valid,
   input  logic                    pay_out_ready,
   output pkt_sync_pkg::pay_beat_t pay_out_beat,

   // register port.
   input  logic                    cfg_wr,
   input  pkt_sync_pkg::reg_addr_t cfg_addr,
   input  pkt_sync_pkg::reg_data_t cfg_wdata,
   output pkt_sync_pkg::reg_data_t cfg_rdata,

   output logic                    sop_mismatch
);

   // ------------------------------
   // internal wiring
   // ------------------------------

   logic                     hdr_q_valid, hdr_q_ready;
   pkt_sync_pkg::hdr_beat_t  hdr_q_beat;
   logic                     pay_q_valid, pay_q_ready;
   pkt_sync_pkg::pay_beat_t  pay_q_beat;
   pkt_sync_pkg::sync_mode_t mode;
   logic                     sync_event;

   // header buffer.
   stream_fifo #(
      .BEAT_T (pkt_sync_pkg::hdr_beat_t),
      .DEPTH  (FIFO_DEPTH)
   ) hdr_fifo (
      .axi4s_in0 (axi4s_in0),
      .arst_n    (arst_n),
      .in_valid  (hdr_in_valid),
      .in_ready  (hdr_in_ready),
      .in_beat   (hdr_in_beat),
      .out_valid (hdr_q_valid),
      .out_ready (hdr_q_ready),
      .out_beat  (hdr_q_beat)
   );

   // payload buffer.
   stream_fifo #(
      .BEAT_T (pkt_sync_pkg::pay_beat_t),
      .DEPTH  (FIFO_DEPTH)
   ) pay_fifo (
      .axi4s_in0 (axi4s_in0),
      .arst_n    (arst_n),
      .in_valid  (pay_in_valid),
      .in_ready  (pay_in_ready),
      .in_beat   (pay_in_beat),
      .out_valid (pay_q_valid),
      .out_ready (pay_q_ready),
      .out_beat  (pay_q_beat)
   );

   // headers on in0, payloads on in1.
   stream_sync #(
      .HDR_T (pkt_sync_pkg::hdr_beat_t),
      .PAY_T (pkt_sync_pkg::pay_beat_t)
   ) sync_i (
      .axi4s_in0    (axi4s_in0),
      .arst_n       (arst_n),
      .mode         (mode),
      .in0_valid    (hdr_q_valid),
      .in0_ready    (hdr_q_ready),
      .in0_beat     (hdr_q_beat),
      .in1_valid    (pay_q_valid),
      .in1_ready    (pay_q_ready),
      .in1_beat     (pay_q_beat),
      .out0_valid   (hdr_out_valid),
      .out0_ready   (hdr_out_ready),
      .out0_beat    (hdr_out_beat),
      .out1_valid   (pay_out_valid),
      .out1_ready   (pay_out_ready),
      .out1_beat    (pay_out_beat),
      .sync_event   (sync_event),
      .sop_mismatch (sop_mismatch)
   );

   sync_regs regs_i (
      .axi4s_in0    (axi4s_in0),
      .arst_n       (arst_n),
      .cfg_wr       (cfg_wr),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .cfg_rdata    (cfg_rdata),
      .sync_event   (sync_event),
      .sop_mismatch (sop_mismatch),
      .mode         (mode)
   );

endmodule

// ==== testbench/pkt_sync_tb.sv ====
/*
 testbench for the header/payload rejoin stage.
 inputs change on the falling edge, outputs are sampled on the rising edge.
 every packet carries exactly one payload beat flagged hdr_tlast.
 each test starts from a fresh reset.
*/

`timescale 1ns/10ps

module pkt_sync_tb;

   localparam int TMO        = 2000;
   localparam int FIFO_DEPTH = 4;

   logic                    axi4s_in0;
   logic                    arst_n;
   logic                    hdr_in_valid, hdr_in_ready;
   pkt_sync_pkg::hdr_beat_t hdr_in_beat;
   logic                    pay_in_valid, pay_in_ready;
   pkt_sync_pkg::pay_beat_t pay_in_beat;
   logic                    hdr_out_valid, hdr_out_ready;
   pkt_sync_pkg::hdr_beat_t hdr_out_beat;
   logic                    pay_out_valid, pay_out_ready;
   pkt_sync_pkg::pay_beat_t pay_out_beat;
   logic                    cfg_wr;
   pkt_sync_pkg::reg_addr_t cfg_addr;
   pkt_sync_pkg::reg_data_t cfg_wdata;
   pkt_sync_pkg::reg_data_t cfg_rdata;
   logic                    sop_mismatch;

   // beats sent and beats still expected on the outputs.
   pkt_sync_pkg::hdr_beat_t hdr_tx[$], exp_hdr[$];
   pkt_sync_pkg::pay_beat_t pay_tx[$], exp_pay[$];
   pkt_sync_pkg::hdr_beat_t hdr_want;
   pkt_sync_pkg::pay_beat_t pay_want;
   pkt_sync_pkg::sync_mode_t cur_mode;

   // output side packet tracking for the ordering checks.
   bit hdr_sop, pay_sop;
   int hdr_pkts, pay_pkts;
   int hdr_sop_shown, pay_sop_shown, pay_tl_shown;
   // beats held in each FIFO, accepted minus released.
   int hdr_occ, pay_occ;
   int errors, test_err, tests, failed_tests;
   int exp_pairs;

   pkt_sync_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut_i (
      .axi4s_in0     (axi4s_in0),
      .arst_n        (arst_n),
      .hdr_in_valid  (hdr_in_valid),
      .hdr_in_ready  (hdr_in_ready),
      .hdr_in_beat   (hdr_in_beat),
      .pay_in_valid  (pay_in_valid),
      .pay_in_ready  (pay_in_ready),
      .pay_in_beat   (pay_in_beat),
      .hdr_out_valid (hdr_out_valid),
      .hdr_out_ready (hdr_out_ready),
      .hdr_out_beat  (hdr_out_beat),
      .pay_out_valid (pay_out_valid),
      .pay_out_ready (pay_out_ready),
      .pay_out_beat  (pay_out_beat),
      .cfg_wr        (cfg_wr),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .cfg_rdata     (cfg_rdata),
      .sop_mismatch  (sop_mismatch)
   );

   initial axi4s_in0 = 1'b0;
   always #5 axi4s_in0 = ~axi4s_in0;

   // ------------------------------
   // helpers
   // ------------------------------

   task automatic report_error(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      errors++;
      test_err++;
   endtask

   task automatic fail_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   task automatic apply_reset();
      @(negedge axi4s_in0);
      arst_n = 1'b0;
      hdr_in_valid  = 1'b0;
      pay_in_valid  = 1'b0;
      hdr_out_ready = 1'b1;
      pay_out_ready = 1'b1;
      cfg_wr = 1'b0;
      hdr_sop = 1'b1;
      pay_sop = 1'b1;
      hdr_pkts = 0;
      pay_pkts = 0;
      hdr_sop_shown = 0;
      pay_sop_shown = 0;
      pay_tl_shown = 0;
      hdr_occ = 0;
      pay_occ = 0;
      hdr_tx.delete();
      pay_tx.delete();
      exp_hdr.delete();
      exp_pay.delete();
      repeat (5) @(posedge axi4s_in0);
      @(negedge axi4s_in0);
      arst_n = 1'b1;
   endtask

   task automatic write_reg(input pkt_sync_pkg::reg_addr_t a, input logic [15:0] d);
      @(negedge axi4s_in0);
      cfg_wr    = 1'b1;
      cfg_addr  = a;
      cfg_wdata = d;
      @(negedge axi4s_in0);
      cfg_wr = 1'b0;
   endtask

   task automatic read_reg(input pkt_sync_pkg::reg_addr_t a, output logic [15:0] d);
      @(negedge axi4s_in0);
      cfg_addr = a;
      @(posedge axi4s_in0);
      d = cfg_rdata;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (test_err != 0) begin
         failed_tests++;
      end
      $display("test %0d %s: %s (%0d errors)", tests, name,
               (test_err == 0) ? "ok" : "failed", test_err);
      test_err = 0;
   endtask

   // ------------------------------
   // stimulus and reference
   // ------------------------------

   // random lengths and data, one hdr_tlast beat per payload packet.
   task automatic build_packets(input int n);
      pkt_sync_pkg::hdr_beat_t h;
      pkt_sync_pkg::pay_beat_t p;
      int hlen, plen, tl;
      for (int k = 0; k < n; k++) begin
         hlen = int'($urandom_range(1, 3));
         plen = int'($urandom_range(1, 4));
         tl   = int'($urandom_range(0, plen - 1));
         for (int i = 0; i < hlen; i++) begin
            h.data = $urandom;
            h.keep = 4'hf;
            h.last = (i == hlen - 1);
            h.pid  = pkt_sync_pkg::pid_t'(k + 16);
            hdr_tx.push_back(h);
         end
         for (int i = 0; i < plen; i++) begin
            p.data      = {$urandom, $urandom};
            p.keep      = 8'hff;
            p.last      = (i == plen - 1);
            p.pid       = pkt_sync_pkg::pid_t'(k + 16);
            p.hdr_tlast = (i == tl);
            pay_tx.push_back(p);
         end
      end
   endtask

   // beats leave unchanged and in order, one meeting per sync point.
   function automatic int ref_model(input pkt_sync_pkg::sync_mode_t m);
      int n;
      n = 0;
      exp_hdr = hdr_tx;
      exp_pay = pay_tx;
      if (m == pkt_sync_pkg::SOP) begin
         foreach (hdr_tx[i]) n += hdr_tx[i].last ? 1 : 0;
      end else begin
         foreach (pay_tx[i]) n += pay_tx[i].hdr_tlast ? 1 : 0;
      end
      return n;
   endfunction

   task automatic drive_hdr(input bit gaps);
      int g, t;
      foreach (hdr_tx[i]) begin
         g = gaps ? int'($urandom_range(0, 3)) : 0;
         repeat (g) begin
            @(negedge axi4s_in0);
            hdr_in_valid = 1'b0;
         end
         @(negedge axi4s_in0);
         hdr_in_valid = 1'b1;
         hdr_in_beat  = hdr_tx[i];
         t = 0;
         forever begin
            @(posedge axi4s_in0);
            if (hdr_in_ready) break;
            t++;
            if (t > TMO) fail_timeout("hdr_in_ready");
         end
      end
      @(negedge axi4s_in0);
      hdr_in_valid = 1'b0;
   endtask

   task automatic drive_pay(input bit gaps);
      int g, t;
      foreach (pay_tx[i]) begin
         g = gaps ? int'($urandom_range(0, 3)) : 0;
         repeat (g) begin
            @(negedge axi4s_in0);
            pay_in_valid = 1'b0;
         end
         @(negedge axi4s_in0);
         pay_in_valid = 1'b1;
         pay_in_beat  = pay_tx[i];
         t = 0;
         forever begin
            @(posedge axi4s_in0);
            if (pay_in_ready) break;
            t++;
            if (t > TMO) fail_timeout("pay_in_ready");
         end
      end
      @(negedge axi4s_in0);
      pay_in_valid = 1'b0;
   endtask

   // waits for all expected beats, toggling the output readys on request.
   task automatic wait_drain(input bit rand_ready);
      int t;
      t = 0;
      while (exp_hdr.size() != 0 || exp_pay.size() != 0) begin
         @(negedge axi4s_in0);
         if (rand_ready) begin
            hdr_out_ready = ($urandom & 32'd1) != 0;
            pay_out_ready = ($urandom & 32'd1) != 0;
         end
         t++;
         if (t > TMO) fail_timeout("the output beats");
      end
      @(negedge axi4s_in0);
      hdr_out_ready = 1'b1;
      pay_out_ready = 1'b1;
   endtask

   task automatic run_traffic(input pkt_sync_pkg::sync_mode_t m, input int n,
                              input bit gaps, input bit rand_ready);
      logic [15:0] d;
      apply_reset();
      cur_mode = m;
      if (m == pkt_sync_pkg::HDR_TLAST) begin
         write_reg(pkt_sync_pkg::REG_MODE, 16'd1);
         read_reg(pkt_sync_pkg::REG_MODE, d);
         assert (d == 16'd1) else report_error("mode register did not take HDR_TLAST");
      end
      build_packets(n);
      exp_pairs = ref_model(m);
      fork
         drive_hdr(gaps);
         drive_pay(gaps);
         wait_drain(rand_ready);
      join
      read_reg(pkt_sync_pkg::REG_PAIRS, d);
      assert (int'(d) == exp_pairs) else report_error("pair count differs");
   endtask

   // ------------------------------
   // output compare
   // ------------------------------

   always @(posedge axi4s_in0) begin
      if (arst_n) begin
         // in_ready is low exactly while that FIFO holds FIFO_DEPTH beats.
         assert (hdr_in_ready == (hdr_occ != FIFO_DEPTH))
            else report_error("hdr_in_ready wrong");
         assert (pay_in_ready == (pay_occ != FIFO_DEPTH))
            else report_error("pay_in_ready wrong");
         if (hdr_in_valid && hdr_in_ready) hdr_occ++;
         if (pay_in_valid && pay_in_ready) pay_occ++;

         // record which packets have shown their meeting beat.
         if (pay_out_valid && pay_sop) pay_sop_shown = pay_pkts + 1;
         if (hdr_out_valid && hdr_sop) hdr_sop_shown = hdr_pkts + 1;
         if (pay_out_valid && pay_out_beat.hdr_tlast) pay_tl_shown = pay_pkts + 1;

         if (hdr_out_valid && hdr_out_ready) begin
            hdr_occ--;
            assert (exp_hdr.size() != 0) else report_error("header beat with none expected");
            if (exp_hdr.size() != 0) begin
               hdr_want = exp_hdr.pop_front();
               assert (hdr_out_beat == hdr_want) else report_error("header beat wrong");
            end
            if (cur_mode == pkt_sync_pkg::SOP && hdr_sop) begin
               assert (pay_sop_shown > hdr_pkts) else report_error("header sop ran ahead");
            end
            if (cur_mode == pkt_sync_pkg::HDR_TLAST && hdr_out_beat.last) begin
               assert (pay_tl_shown > hdr_pkts) else report_error("header last ran ahead");
            end
            hdr_sop = hdr_out_beat.last;
            if (hdr_out_beat.last) hdr_pkts++;
         end

         if (pay_out_valid && pay_out_ready) begin
            pay_occ--;
            assert (exp_pay.size() != 0) else report_error("payload beat with none expected");
            if (exp_pay.size() != 0) begin
               pay_want = exp_pay.pop_front();
               assert (pay_out_beat == pay_want) else report_error("payload beat wrong");
            end
            if (cur_mode == pkt_sync_pkg::SOP && pay_sop) begin
               assert (hdr_sop_shown > pay_pkts) else report_error("payload sop ran ahead");
            end
            pay_sop = pay_out_beat.last;
            if (pay_out_beat.last) pay_pkts++;
         end
      end
   end

   // ------------------------------
   // test sequence
   // ------------------------------

   initial begin
      logic [15:0] d;
      int t;
      void'($urandom(32'h16ee_28d5));
      errors = 0;
      test_err = 0;
      tests = 0;
      failed_tests = 0;
      hdr_occ = 0;
      pay_occ = 0;
      cur_mode = pkt_sync_pkg::SOP;
      arst_n = 1'b0;
      hdr_in_valid = 1'b0;
      hdr_in_beat = '0;
      pay_in_valid = 1'b0;
      pay_in_beat = '0;
      hdr_out_ready = 1'b1;
      pay_out_ready = 1'b1;
      cfg_wr = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;

      apply_reset();
      assert (!hdr_out_valid && !pay_out_valid) else report_error("valid high after reset");
      read_reg(pkt_sync_pkg::REG_MODE, d);
      assert (d == 16'd0) else report_error("mode not SOP after reset");
      read_reg(pkt_sync_pkg::REG_PAIRS, d);
      assert (d == 16'd0) else report_error("pair count not zero");
      read_reg(pkt_sync_pkg::REG_MISMATCH, d);
      assert (d == 16'd0) else report_error("mismatch count not zero");
      end_test("reset state");

      run_traffic(pkt_sync_pkg::SOP, 8, 1'b0, 1'b0);
      end_test("sop straight through");
      run_traffic(pkt_sync_pkg::SOP, 10, 1'b1, 1'b0);
      end_test("sop random input gaps");
      run_traffic(pkt_sync_pkg::SOP, 12, 1'b1, 1'b1);
      end_test("sop random output readys");

      // a header and a payload sop with different pids.
      apply_reset();
      cur_mode = pkt_sync_pkg::SOP;
      @(negedge axi4s_in0);
      hdr_in_valid = 1'b1;
      hdr_in_beat  = '{data: 32'h1234_5678, keep: 4'hf, last: 1'b1, pid: 8'd1};
      pay_in_valid = 1'b1;
      pay_in_beat  = '0;
      pay_in_beat.pid  = 8'd2;
      pay_in_beat.last = 1'b1;
      @(negedge axi4s_in0);
      hdr_in_valid = 1'b0;
      pay_in_valid = 1'b0;
      t = 0;
      while (!sop_mismatch) begin
         @(posedge axi4s_in0);
         t++;
         if (t > TMO) fail_timeout("sop_mismatch");
      end
      repeat (20) begin
         @(posedge axi4s_in0);
         assert (!hdr_out_valid && !pay_out_valid) else report_error("stalled beat shown");
      end
      read_reg(pkt_sync_pkg::REG_MISMATCH, d);
      assert (d == 16'd1) else report_error("mismatch count not one");
      read_reg(pkt_sync_pkg::REG_STATUS, d);
      assert (d == 16'd1) else report_error("status does not show mismatch");
      apply_reset();
      read_reg(pkt_sync_pkg::REG_STATUS, d);
      assert (d == 16'd0 && !hdr_out_valid) else report_error("reset left mismatch state");
      end_test("pid mismatch");

      run_traffic(pkt_sync_pkg::HDR_TLAST, 10, 1'b1, 1'b1);
      end_test("hdr_tlast mode");

      $display("totals: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
rtl/pkt_sync_pkg.sv
rtl/stream_fifo.sv
rtl/stream_sync.sv
rtl/sync_regs.sv
rtl/pkt_sync_top.sv
testbench/pkt_sync_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass means the pass line was printed.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module pkt_sync_tb -o pkt_sync_sim \
   && out=$(./obj_dir/pkt_sync_sim) \
   ; echo "$out" \
   && echo "$out" | grep -q "TESTBENCH PASSED" \
   && exit 0 \
   || exit 1
